// ==== verilog/lbd_pkg.sv ====
`default_nettype none

package lbd_pkg;

   // fetch bundle geometry
   localparam int SLOTS  = 4;
   localparam int ADDR_W = 16;

   // one instruction address
   typedef logic [ADDR_W-1:0] pc_addr_t;

   // slot i sits at bits 16i +: 16
   // slot 0 is first in program order
   typedef logic [SLOTS*ADDR_W-1:0] bundle_t;

   // one bit per slot, bit i is slot i
   typedef logic [SLOTS-1:0] slot_mask_t;

   // loop body instruction count
   typedef logic [6:0] body_len_t;

   // unroll iterations, max or remaining
   typedef logic [6:0] unroll_t;

   // instructions per dispatch
   // also the longest body that may be trained
   localparam int STALL_BUDGET = 64;

   // detector FSM
   typedef enum logic [1:0] {
      IDLE     = 2'b00,
      TRAIN    = 2'b01,
      DISPATCH = 2'b10
   } lbd_state_e;

endpackage

`default_nettype wire

// ==== verilog/lbd_fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module lbd_fetch_stage (
   input  logic              clk,
   input  logic              reset,
   input  logic              bundle_valid,
   input  logic              mis_pred,
   input  lbd_pkg::bundle_t  pc_bundle,
   input  lbd_pkg::slot_mask_t back_loop,
   output logic              s1_valid,
   output logic              s1_mis_pred,
   output logic              s1_branch_seen,
   output lbd_pkg::bundle_t  s1_bundle,
   output lbd_pkg::pc_addr_t s1_fallthrough
);

   lbd_pkg::pc_addr_t branch_addr;
   lbd_pkg::pc_addr_t fall_cand;

   // first flagged slot in program order
   // walk from the top so the lowest slot wins
   always_comb begin
      branch_addr = pc_bundle[lbd_pkg::ADDR_W-1:0];
      for (int i = lbd_pkg::SLOTS - 1; i >= 0; i--) begin
         if (back_loop[i]) begin
            branch_addr = pc_bundle[i*lbd_pkg::ADDR_W +: lbd_pkg::ADDR_W];
         end
      end
   end

   // instruction right after the backward branch
   assign fall_cand = branch_addr + lbd_pkg::pc_addr_t'(1);

   // strobe follows bundle_valid by one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= bundle_valid;
      end
   end

   // bundle payload, held until the next strobe
   always_ff @(posedge clk) begin
      if (bundle_valid) begin
         s1_bundle      <= pc_bundle;
         s1_mis_pred    <= mis_pred;
         s1_branch_seen <= |back_loop;
         s1_fallthrough <= fall_cand;
      end
   end

   // back-to-back stage outputs need back-to-back bundles
   a_s1_b2b : assert property (@(posedge clk) disable iff (reset)
      s1_valid && $past(s1_valid) |-> $past(bundle_valid) && $past(bundle_valid, 2));

endmodule

`default_nettype wire

// ==== verilog/loop_addr_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module loop_addr_table #(
   parameter int LAT_ENTRIES = 4
) (
   input  logic                clk,
   input  logic                reset,
   input  lbd_pkg::pc_addr_t   lookup_addr,
   output logic                hit,
   output lbd_pkg::pc_addr_t   hit_fallthrough,
   output lbd_pkg::unroll_t    hit_unroll,
   input  logic                lat_write,
   input  lbd_pkg::pc_addr_t   wr_start,
   input  lbd_pkg::pc_addr_t   wr_fallthrough,
   input  lbd_pkg::body_len_t  wr_body_len
);

   localparam int PTR_W = $clog2(LAT_ENTRIES);

   logic [LAT_ENTRIES-1:0] ent_valid;
   lbd_pkg::pc_addr_t      ent_start [LAT_ENTRIES];
   lbd_pkg::pc_addr_t      ent_fall [LAT_ENTRIES];
   lbd_pkg::unroll_t       ent_unroll [LAT_ENTRIES];
   logic [PTR_W-1:0]       wr_ptr;
   lbd_pkg::unroll_t       new_unroll;

   // how many whole bodies fit in one dispatch budget
   assign new_unroll = lbd_pkg::unroll_t'(lbd_pkg::STALL_BUDGET / int'(wr_body_len));

   // valid bits and round-robin pointer
   // pointer wraps on its own since depth is a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         ent_valid <= '0;
         wr_ptr    <= '0;
      end else if (lat_write) begin
         ent_valid[wr_ptr] <= 1'b1;
         wr_ptr            <= wr_ptr + 1'b1;
      end
   end

   // entry fields
   always_ff @(posedge clk) begin
      if (lat_write) begin
         ent_start[wr_ptr]  <= wr_start;
         ent_fall[wr_ptr]   <= wr_fallthrough;
         ent_unroll[wr_ptr] <= new_unroll;
      end
   end

   // start address match
   // lowest valid entry wins, old contents during a write
   always_comb begin
      hit             = 1'b0;
      hit_fallthrough = '0;
      hit_unroll      = '0;
      for (int i = LAT_ENTRIES - 1; i >= 0; i--) begin
         if (ent_valid[i] && (ent_start[i] == lookup_addr)) begin
            hit             = 1'b1;
            hit_fallthrough = ent_fall[i];
            hit_unroll      = ent_unroll[i];
         end
      end
   end

   // trained body must fit the budget and be non-empty
   a_wr_len : assert property (@(posedge clk) disable iff (reset)
      lat_write |-> (wr_body_len != '0) && (int'(wr_body_len) <= lbd_pkg::STALL_BUDGET));

endmodule

`default_nettype wire

// ==== verilog/loop_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module loop_controller #(
   parameter int LAT_ENTRIES = 4
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                s1_valid,
   input  logic                s1_mis_pred,
   input  logic                s1_branch_seen,
   input  lbd_pkg::bundle_t    s1_bundle,
   input  lbd_pkg::pc_addr_t   s1_fallthrough,
   output lbd_pkg::pc_addr_t   lookup_addr,
   input  logic                hit,
   input  lbd_pkg::pc_addr_t   hit_fallthrough,
   input  lbd_pkg::unroll_t    hit_unroll,
   output logic                lat_write,
   output lbd_pkg::pc_addr_t   wr_start,
   output lbd_pkg::pc_addr_t   wr_fallthrough,
   output lbd_pkg::body_len_t  wr_body_len,
   output logic                out_valid,
   output logic                loop_start,
   output logic                fnsh_unroll,
   output lbd_pkg::slot_mask_t inst_valid,
   output lbd_pkg::lbd_state_e lbd_state
);

   localparam int IDX_W  = $clog2(lbd_pkg::SLOTS);
   localparam int FILL_W = $clog2(LAT_ENTRIES + 1);

   lbd_pkg::pc_addr_t   slot_addr [lbd_pkg::SLOTS];
   lbd_pkg::pc_addr_t   cmp_fall;
   lbd_pkg::pc_addr_t   train_fall;
   lbd_pkg::pc_addr_t   disp_fall;
   lbd_pkg::pc_addr_t   start_addr;
   lbd_pkg::body_len_t  body_cnt;
   lbd_pkg::body_len_t  body_inc;
   lbd_pkg::body_len_t  train_total;
   lbd_pkg::unroll_t    remaining;
   lbd_pkg::unroll_t    cur_remaining;
   lbd_pkg::slot_mask_t end_mask;
   logic [IDX_W-1:0]    end_slot;
   logic                end_found;
   logic                over_budget;
   logic                hit_start;
   logic                disp_bundle;
   logic                disp_done;
   logic [FILL_W-1:0]   fill_cnt;

   // split bundle into slot addresses
   always_comb begin
      for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
         slot_addr[i] = s1_bundle[i*lbd_pkg::ADDR_W +: lbd_pkg::ADDR_W];
      end
   end

   // table is probed with slot 0
   assign lookup_addr = slot_addr[0];

   // fallthrough to compare against
   // idle uses the table answer for a fresh hit
   always_comb begin
      case (lbd_state)
         lbd_pkg::TRAIN:    cmp_fall = train_fall;
         lbd_pkg::DISPATCH: cmp_fall = disp_fall;
         default:           cmp_fall = hit_fallthrough;
      endcase
   end

   // lowest slot whose next address is the fallthrough
   always_comb begin
      end_found = 1'b0;
      end_slot  = '0;
      for (int i = lbd_pkg::SLOTS - 1; i >= 0; i--) begin
         if (slot_addr[i] + lbd_pkg::pc_addr_t'(1) == cmp_fall) begin
            end_found = 1'b1;
            end_slot  = IDX_W'(i);
         end
      end
   end

   // slots 0 .. end slot, all slots when no end
   always_comb begin
      for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
         end_mask[i] = !end_found || (IDX_W'(i) <= end_slot);
      end
   end

   // body length bookkeeping
   assign body_inc    = end_found ? lbd_pkg::body_len_t'(end_slot) + lbd_pkg::body_len_t'(1)
                                  : lbd_pkg::body_len_t'(lbd_pkg::SLOTS);
   assign train_total = body_cnt + body_inc;
   assign over_budget = int'(train_total) > lbd_pkg::STALL_BUDGET;

   // dispatch decisions
   assign hit_start     = (lbd_state == lbd_pkg::IDLE) && !s1_mis_pred && hit;
   assign disp_bundle   = hit_start || (lbd_state == lbd_pkg::DISPATCH);
   assign cur_remaining = hit_start ? hit_unroll : remaining;
   assign disp_done     = disp_bundle && !s1_mis_pred && end_found &&
                          (cur_remaining == lbd_pkg::unroll_t'(1));

   // table write on a clean loop end within budget
   assign lat_write = s1_valid && (lbd_state == lbd_pkg::TRAIN) && !s1_mis_pred &&
                      end_found && !over_budget;
   // a short body may end in its first bundle
   assign wr_start       = (body_cnt == '0) ? slot_addr[0] : start_addr;
   assign wr_fallthrough = train_fall;
   assign wr_body_len    = train_total;

   // FSM and output registers
   always_ff @(posedge clk) begin
      if (reset) begin
         lbd_state   <= lbd_pkg::IDLE;
         out_valid   <= 1'b0;
         loop_start  <= 1'b0;
         fnsh_unroll <= 1'b0;
         inst_valid  <= '1;
      end else begin
         out_valid   <= s1_valid;
         loop_start  <= s1_valid && hit_start;
         fnsh_unroll <= s1_valid && disp_done;
         if (s1_valid) begin
            inst_valid <= disp_bundle ? end_mask : '1;
            case (lbd_state)
               lbd_pkg::IDLE: begin
                  if (hit_start) begin
                     lbd_state <= disp_done ? lbd_pkg::IDLE : lbd_pkg::DISPATCH;
                  end else if (!s1_mis_pred && s1_branch_seen) begin
                     lbd_state <= lbd_pkg::TRAIN;
                  end
               end
               lbd_pkg::TRAIN: begin
                  // end found, over budget or mispredict all leave
                  if (s1_mis_pred || end_found || over_budget) begin
                     lbd_state <= lbd_pkg::IDLE;
                  end
               end
               lbd_pkg::DISPATCH: begin
                  if (s1_mis_pred || disp_done) begin
                     lbd_state <= lbd_pkg::IDLE;
                  end
               end
               default: lbd_state <= lbd_pkg::IDLE;
            endcase
         end
      end
   end

   // body and unroll counters
   always_ff @(posedge clk) begin
      if (reset) begin
         body_cnt  <= '0;
         remaining <= '0;
      end else if (s1_valid) begin
         if (lbd_state == lbd_pkg::IDLE) begin
            body_cnt <= '0;
         end else if (lbd_state == lbd_pkg::TRAIN) begin
            body_cnt <= train_total;
         end
         // one iteration used per loop end seen
         if (disp_bundle && end_found) begin
            remaining <= cur_remaining - lbd_pkg::unroll_t'(1);
         end else if (hit_start) begin
            remaining <= hit_unroll;
         end
      end
   end

   // loop addresses
   always_ff @(posedge clk) begin
      if (s1_valid) begin
         if (lbd_state == lbd_pkg::IDLE) begin
            train_fall <= s1_fallthrough;
         end
         if ((lbd_state == lbd_pkg::TRAIN) && (body_cnt == '0)) begin
            start_addr <= slot_addr[0];
         end
         if (hit_start) begin
            disp_fall <= hit_fallthrough;
         end
      end
   end

   // trained loops so far, saturates at table depth
   always_ff @(posedge clk) begin
      if (reset) begin
         fill_cnt <= '0;
      end else if (lat_write && (fill_cnt != FILL_W'(LAT_ENTRIES))) begin
         fill_cnt <= fill_cnt + 1'b1;
      end
   end

   // a new loop never starts on the bundle where the budget runs out
   a_start_fnsh : assert property (@(posedge clk) disable iff (reset)
      !(loop_start && fnsh_unroll));

   // a write ends training on the same edge
   a_write_train : assert property (@(posedge clk) disable iff (reset)
      lat_write |-> (lbd_state == lbd_pkg::TRAIN) ##1 (lbd_state == lbd_pkg::IDLE));

   // empty table since reset gives no hit
   a_hit_filled : assert property (@(posedge clk) disable iff (reset)
      s1_valid && hit |-> fill_cnt != '0);

endmodule

`default_nettype wire

// ==== verilog/lbd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lbd_top #(
   parameter int LAT_ENTRIES = 4
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                bundle_valid,
   input  lbd_pkg::bundle_t    pc_bundle,
   input  lbd_pkg::slot_mask_t back_loop,
   input  logic                mis_pred,
   output logic                out_valid,
   output lbd_pkg::slot_mask_t inst_valid,
   output logic                loop_start,
   output logic                fnsh_unroll,
   output lbd_pkg::lbd_state_e lbd_state
);

   // stage 1 to controller
   logic               s1_valid;
   logic               s1_mis_pred;
   logic               s1_branch_seen;
   lbd_pkg::bundle_t   s1_bundle;
   lbd_pkg::pc_addr_t  s1_fallthrough;

   // controller to table and back
   lbd_pkg::pc_addr_t  lookup_addr;
   logic               hit;
   lbd_pkg::pc_addr_t  hit_fallthrough;
   lbd_pkg::unroll_t   hit_unroll;
   logic               lat_write;
   lbd_pkg::pc_addr_t  wr_start;
   lbd_pkg::pc_addr_t  wr_fallthrough;
   lbd_pkg::body_len_t wr_body_len;

   // bundle capture and branch pre-decode
   lbd_fetch_stage u_fetch (
      .clk            (clk),
      .reset          (reset),
      .bundle_valid   (bundle_valid),
      .mis_pred       (mis_pred),
      .pc_bundle      (pc_bundle),
      .back_loop      (back_loop),
      .s1_valid       (s1_valid),
      .s1_mis_pred    (s1_mis_pred),
      .s1_branch_seen (s1_branch_seen),
      .s1_bundle      (s1_bundle),
      .s1_fallthrough (s1_fallthrough)
   );

   // train and dispatch FSM
   loop_controller #(
      .LAT_ENTRIES (LAT_ENTRIES)
   ) u_ctrl (
      .clk             (clk),
      .reset           (reset),
      .s1_valid        (s1_valid),
      .s1_mis_pred     (s1_mis_pred),
      .s1_branch_seen  (s1_branch_seen),
      .s1_bundle       (s1_bundle),
      .s1_fallthrough  (s1_fallthrough),
      .lookup_addr     (lookup_addr),
      .hit             (hit),
      .hit_fallthrough (hit_fallthrough),
      .hit_unroll      (hit_unroll),
      .lat_write       (lat_write),
      .wr_start        (wr_start),
      .wr_fallthrough  (wr_fallthrough),
      .wr_body_len     (wr_body_len),
      .out_valid       (out_valid),
      .loop_start      (loop_start),
      .fnsh_unroll     (fnsh_unroll),
      .inst_valid      (inst_valid),
      .lbd_state       (lbd_state)
   );

   // loop address table beside stage 2
   loop_addr_table #(
      .LAT_ENTRIES (LAT_ENTRIES)
   ) u_lat (
      .clk             (clk),
      .reset           (reset),
      .lookup_addr     (lookup_addr),
      .hit             (hit),
      .hit_fallthrough (hit_fallthrough),
      .hit_unroll      (hit_unroll),
      .lat_write       (lat_write),
      .wr_start        (wr_start),
      .wr_fallthrough  (wr_fallthrough),
      .wr_body_len     (wr_body_len)
   );

endmodule

`default_nettype wire

// ==== verif/lbd_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lbd_tb;

   localparam int LAT_ENTRIES = 4;
   // roughly 100 bundles over all tests, two cycles each plus slack
   localparam int BUNDLE_EST = 100;
   localparam int TIMEOUT_CYCLES = 2 * BUNDLE_EST + 100;

   logic                clk;
   logic                reset;
   logic                bundle_valid;
   lbd_pkg::bundle_t    pc_bundle;
   lbd_pkg::slot_mask_t back_loop;
   logic                mis_pred;
   logic                out_valid;
   lbd_pkg::slot_mask_t inst_valid;
   logic                loop_start;
   logic                fnsh_unroll;
   lbd_pkg::lbd_state_e lbd_state;

   integer seed = 32'hd670b0c4;
   int     errors = 0;
   int     err_mark = 0;
   int     sent = 0;
   int     cycles = 0;

   // expected record {valid, inst[3:0], start, fnsh, state[1:0]}
   logic [8:0] exp_q [$];
   logic [8:0] chk_rec = 9'h0f0;

   // reference model state
   lbd_pkg::lbd_state_e m_state = lbd_pkg::IDLE;
   lbd_pkg::slot_mask_t m_inst = 4'hf;
   lbd_pkg::pc_addr_t   m_train_fall = '0;
   lbd_pkg::pc_addr_t   m_disp_fall = '0;
   lbd_pkg::pc_addr_t   m_start = '0;
   int                  m_body = 0;
   int                  m_rem = 0;
   logic                tab_valid [LAT_ENTRIES];
   lbd_pkg::pc_addr_t   tab_start [LAT_ENTRIES];
   lbd_pkg::pc_addr_t   tab_fall [LAT_ENTRIES];
   int                  tab_unroll [LAT_ENTRIES];
   int                  tab_ptr = 0;

   lbd_top #(
      .LAT_ENTRIES (LAT_ENTRIES)
   ) u_dut (
      .clk          (clk),
      .reset        (reset),
      .bundle_valid (bundle_valid),
      .pc_bundle    (pc_bundle),
      .back_loop    (back_loop),
      .mis_pred     (mis_pred),
      .out_valid    (out_valid),
      .inst_valid   (inst_valid),
      .loop_start   (loop_start),
      .fnsh_unroll  (fnsh_unroll),
      .lbd_state    (lbd_state)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

   // line the expected record up with the DUT's two-cycle latency
   initial begin
      logic [8:0] nxt;
      forever begin
         @(posedge clk);
         if (exp_q.size() >= 2) begin
            nxt = exp_q.pop_front();
            chk_rec <= nxt;
         end
      end
   end

   task automatic mismatch(input string name, input logic [3:0] got, input logic [3:0] exp);
      errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
   endtask

   // outputs only move on posedge, so negedge sees them settled
   a_valid : assert property (@(negedge clk) disable iff (reset) out_valid == chk_rec[8])
      else mismatch("out_valid", {3'b000, out_valid}, {3'b000, chk_rec[8]});
   a_inst : assert property (@(negedge clk) disable iff (reset) inst_valid == chk_rec[7:4])
      else mismatch("inst_valid", inst_valid, chk_rec[7:4]);
   a_start : assert property (@(negedge clk) disable iff (reset) loop_start == chk_rec[3])
      else mismatch("loop_start", {3'b000, loop_start}, {3'b000, chk_rec[3]});
   a_fnsh : assert property (@(negedge clk) disable iff (reset) fnsh_unroll == chk_rec[2])
      else mismatch("fnsh_unroll", {3'b000, fnsh_unroll}, {3'b000, chk_rec[2]});
   a_state : assert property (@(negedge clk) disable iff (reset)
      lbd_state == lbd_pkg::lbd_state_e'(chk_rec[1:0]))
      else mismatch("lbd_state", {2'b00, lbd_state}, {2'b00, chk_rec[1:0]});

   // first slot whose next address is the fallthrough, -1 if none
   function automatic int find_end(input lbd_pkg::bundle_t b, input lbd_pkg::pc_addr_t fall);
      int e;
      e = -1;
      for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
         if (e < 0 && b[i*lbd_pkg::ADDR_W +: lbd_pkg::ADDR_W] + 16'd1 == fall) begin
            e = i;
         end
      end
      return e;
   endfunction

   function automatic lbd_pkg::slot_mask_t mask_to(input int e);
      lbd_pkg::slot_mask_t m;
      m = 4'hf;
      for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
         m[i] = (e < 0) || (i <= e);
      end
      return m;
   endfunction

   function automatic lbd_pkg::bundle_t seq_bundle(input lbd_pkg::pc_addr_t base);
      return {base + 16'd3, base + 16'd2, base + 16'd1, base};
   endfunction

   // one dispatched bundle against the loop end
   task automatic dispatch_one(input lbd_pkg::bundle_t b, inout logic fn);
      int e;
      e = find_end(b, m_disp_fall);
      m_inst = mask_to(e);
      if (e >= 0) begin
         m_rem--;
         if (m_rem == 0) begin
            fn = 1'b1;
            m_state = lbd_pkg::IDLE;
         end
      end
   endtask

   task automatic model_bundle(input lbd_pkg::bundle_t b, input lbd_pkg::slot_mask_t bl,
                               input logic mp, inout logic ls, inout logic fn);
      lbd_pkg::pc_addr_t a0;
      int h;
      int e;
      int total;
      logic got;
      a0 = b[lbd_pkg::ADDR_W-1:0];
      m_inst = 4'hf;
      case (m_state)
         lbd_pkg::IDLE: begin
            h = -1;
            for (int i = 0; i < LAT_ENTRIES; i++) begin
               if (h < 0 && tab_valid[i] && tab_start[i] == a0) h = i;
            end
            if (!mp && h >= 0) begin
               ls = 1'b1;
               m_rem = tab_unroll[h];
               m_disp_fall = tab_fall[h];
               m_state = lbd_pkg::DISPATCH;
               dispatch_one(b, fn);
            end else if (!mp && bl != '0) begin
               got = 1'b0;
               for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
                  if (bl[i] && !got) begin
                     m_train_fall = b[i*lbd_pkg::ADDR_W +: lbd_pkg::ADDR_W] + 16'd1;
                     got = 1'b1;
                  end
               end
               m_body = 0;
               m_state = lbd_pkg::TRAIN;
            end
         end
         lbd_pkg::TRAIN: begin
            if (mp) begin
               m_state = lbd_pkg::IDLE;
            end else begin
               if (m_body == 0) m_start = a0;
               e = find_end(b, m_train_fall);
               total = m_body + ((e >= 0) ? e + 1 : lbd_pkg::SLOTS);
               if (total > lbd_pkg::STALL_BUDGET) begin
                  m_state = lbd_pkg::IDLE;
               end else if (e >= 0) begin
                  tab_valid[tab_ptr] = 1'b1;
                  tab_start[tab_ptr] = m_start;
                  tab_fall[tab_ptr] = m_train_fall;
                  tab_unroll[tab_ptr] = lbd_pkg::STALL_BUDGET / total;
                  tab_ptr = (tab_ptr + 1) % LAT_ENTRIES;
                  m_state = lbd_pkg::IDLE;
               end else begin
                  m_body = total;
               end
            end
         end
         default: begin
            // mask still applies on a mispredicted dispatch bundle
            if (mp) begin
               m_inst = mask_to(find_end(b, m_disp_fall));
               m_state = lbd_pkg::IDLE;
            end else begin
               dispatch_one(b, fn);
            end
         end
      endcase
   endtask

   // one falling edge, one expected record
   task automatic step(input logic v, input lbd_pkg::bundle_t b,
                       input lbd_pkg::slot_mask_t bl, input logic mp);
      logic ls;
      logic fn;
      @(negedge clk);
      bundle_valid = v;
      pc_bundle = b;
      back_loop = bl;
      mis_pred = mp;
      ls = 1'b0;
      fn = 1'b0;
      if (v) begin
         model_bundle(b, bl, mp, ls, fn);
         sent++;
      end
      exp_q.push_back({v, m_inst, ls, fn, m_state});
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) step(1'b0, '0, '0, 1'b0);
   endtask

   // filler addresses keep bit 15 set, loops live below it
   task automatic send_filler();
      lbd_pkg::bundle_t b;
      for (int i = 0; i < lbd_pkg::SLOTS; i++) begin
         b[i*lbd_pkg::ADDR_W +: lbd_pkg::ADDR_W] = {1'b1, 15'($random(seed))};
      end
      step(1'b1, b, '0, 1'b0);
   endtask

   task automatic run_iteration(input lbd_pkg::pc_addr_t start, input int len);
      for (int k = 0; k < len; k += 4) begin
         step(1'b1, seq_bundle(start + lbd_pkg::pc_addr_t'(k)), '0, 1'b0);
      end
   endtask

   // branch in slot 0 jumps back to start, then the body once
   task automatic train_loop(input lbd_pkg::pc_addr_t start, input int len);
      step(1'b1, seq_bundle(start + lbd_pkg::pc_addr_t'(len - 1)), 4'b0001, 1'b0);
      run_iteration(start, len);
   endtask

   task automatic end_test(input string name);
      idle_cycles(3);
      $display("test %s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      reset = 1'b1;
      bundle_valid = 1'b0;
      pc_bundle = '0;
      back_loop = '0;
      mis_pred = 1'b0;
      for (int i = 0; i < LAT_ENTRIES; i++) begin
         tab_valid[i] = 1'b0;
         tab_start[i] = '0;
         tab_fall[i] = '0;
         tab_unroll[i] = 0;
      end
      idle_cycles(8);
      reset = 1'b0;

      idle_cycles(4);
      end_test("1 reset values");

      repeat (8) send_filler();
      end_test("2 random fillers");

      // length 10, end lands in slot 1
      train_loop(16'h1000, 10);
      idle_cycles(2);
      run_iteration(16'h1000, 10);
      end_test("3 train and loop start");

      // iterations 2 to 6 of 64 / 10
      repeat (5) run_iteration(16'h1000, 10);
      end_test("4 unroll budget");

      step(1'b1, seq_bundle(16'h1000), '0, 1'b0);
      step(1'b1, seq_bundle(16'h1004), '0, 1'b1);
      send_filler();
      train_loop(16'h3000, 70);
      idle_cycles(2);
      step(1'b1, seq_bundle(16'h3000), '0, 1'b0);
      end_test("5 abort cases");

      // five new loops wrap the pointer past the first of them
      for (int i = 0; i <= LAT_ENTRIES; i++) begin
         train_loop(16'h4000 + lbd_pkg::pc_addr_t'(i * 256), 5 + 2 * i);
         idle_cycles(1);
      end
      step(1'b1, seq_bundle(16'h4000), '0, 1'b0);
      run_iteration(16'h4400, 13);
      step(1'b1, seq_bundle(16'h4400), '0, 1'b1);
      end_test("6 replacement");

      $display("bundles sent %0d, errors %0d", sent, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/lbd_pkg.sv
verilog/lbd_fetch_stage.sv
verilog/loop_addr_table.sv
verilog/loop_controller.sv
verilog/lbd_top.sv
verif/lbd_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -Wall
TOP   = lbd_tb
FLIST = flist.f

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir
